//--- verilog.f
common/alu_pkg.sv
verilog/issue_sequencer.sv
fx_arith/fx_arith_unit.sv
bit_manip/bit_manip_unit.sv
verilog/result_stage.sv
verilog/alu_top.sv
bench/alu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with verilator, run, then decide on the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module alu_tb -f verilog.f \
    --Mdir obj_dir -o alu_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/alu_sim > sim.log 2>&1
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

//--- bench/alu_tb.sv
`timescale 1ns/1ps

module alu_tb;

    localparam int INT_W        = 6;
    localparam int FRAC_W       = 10;
    localparam int DATA_W       = INT_W + FRAC_W;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int N_RANDOM     = 32;

    typedef struct packed {
        logic [3:0]        op;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] expected;
    } row_t;

    logic              i_clk;
    logic              i_rst_n;
    logic [DATA_W-1:0] i_data_a;
    logic [DATA_W-1:0] i_data_b;
    logic [3:0]        i_inst;
    logic              o_valid;
    logic              o_busy;
    logic [DATA_W-1:0] o_data;

    row_t        rows[$];
    bit          rows_built = 1'b0;
    bit          rhythm_on  = 1'b0;
    logic        last_valid = 1'b0;
    int          err_count  = 0;
    logic [31:0] lcg_state  = 32'h7322;

    alu_top #(
        .INT_W  (INT_W),
        .FRAC_W (FRAC_W)
    ) alu_top_inst (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_data_a (i_data_a),
        .i_data_b (i_data_b),
        .i_inst   (i_inst),
        .o_valid  (o_valid),
        .o_busy   (o_busy),
        .o_data   (o_data)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [DATA_W-1:0] saturate(input longint v);
        logic [DATA_W-1:0] w;
        if (v > (longint'(1) <<< (DATA_W - 1)) - 1) begin
            w = {1'b0, {(DATA_W - 1){1'b1}}};
        end else if (v < -(longint'(1) <<< (DATA_W - 1))) begin
            w = {1'b1, {(DATA_W - 1){1'b0}}};
        end else begin
            w = v[DATA_W-1:0];
        end
        return w;
    endfunction

    function automatic logic [DATA_W-1:0] leading_zeros(input logic [DATA_W-1:0] v);
        int count;
        count = 0;
        for (int i = DATA_W - 1; i >= 0; i--) begin
            if (v[i]) break;
            count++;
        end
        return DATA_W'(count);
    endfunction

    // one bit at a time, each wrapped bit comes back inverted
    function automatic logic [DATA_W-1:0] rotate_complement(input logic [DATA_W-1:0] a,
                                                             input logic [DATA_W-1:0] b);
        logic [DATA_W-1:0] r;
        r = b;
        for (int k = 0; k < $countones(a); k++) begin
            r = {r[DATA_W-2:0], ~r[DATA_W-1]};
        end
        return r;
    endfunction

    function automatic logic [DATA_W-1:0] lfsr_steps(input logic [DATA_W-1:0] a,
                                                      input logic [DATA_W-1:0] b);
        logic [DATA_W-1:0] s;
        logic              fb;
        s = a;
        if (b > DATA_W'(8)) begin
            s = '0;
        end else begin
            for (int k = 0; k < int'(b); k++) begin
                fb = s[DATA_W-1] ^ s[DATA_W-3] ^ s[DATA_W-4] ^ s[DATA_W-6];
                s  = {s[DATA_W-2:0], fb};
            end
        end
        return s;
    endfunction

    function automatic logic [DATA_W-1:0] expected_result(input logic [3:0] op,
            input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
            input logic [DATA_W-1:0] acc);
        longint            sa;
        longint            sb;
        longint            prod;
        logic [DATA_W-1:0] w;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        case (op)
            alu_pkg::OP_FXADD: w = saturate(sa + sb);
            alu_pkg::OP_FXSUB: w = saturate(sa - sb);
            alu_pkg::OP_FXMUL, alu_pkg::OP_FXMAC: begin
                prod = sa * sb;
                if (op == alu_pkg::OP_FXMAC) begin
                    prod = prod + longint'($signed(acc)) * (longint'(1) <<< FRAC_W);
                end
                w = saturate((prod >>> FRAC_W) + longint'(prod[FRAC_W-1]));  // half up
            end
            alu_pkg::OP_CLZ:   w = leading_zeros(a);
            alu_pkg::OP_LRCW:  w = rotate_complement(a, b);
            alu_pkg::OP_LFSR:  w = lfsr_steps(a, b);
            default:           w = '0;
        endcase
        return w;
    endfunction

    task automatic add_row(input logic [3:0] op, input logic [DATA_W-1:0] a,
                           input logic [DATA_W-1:0] b);
        row_t r;
        r.op       = op;
        r.a        = a;
        r.b        = b;
        r.expected = '0;
        rows.push_back(r);
    endtask

    task automatic build_rows();
        logic [31:0]       rnd;
        logic [DATA_W-1:0] acc_model;
        row_t              r;
        add_row(alu_pkg::OP_FXADD, 16'h0600, 16'h0900);
        add_row(alu_pkg::OP_FXADD, 16'h7E00, 16'h0400);  // 31.5 + 1.0
        add_row(alu_pkg::OP_FXADD, 16'h8000, 16'hFC00);
        add_row(alu_pkg::OP_FXSUB, 16'h0800, 16'h0E00);
        add_row(alu_pkg::OP_FXSUB, 16'h8000, 16'h0400);  // -32 - 1
        add_row(alu_pkg::OP_FXSUB, 16'h7E00, 16'hFC00);
        add_row(alu_pkg::OP_FXMUL, 16'h0600, 16'h0800);
        add_row(alu_pkg::OP_FXMUL, 16'h0001, 16'h0200);  // exactly half an lsb
        add_row(alu_pkg::OP_FXMUL, 16'hFFFF, 16'h0200);
        add_row(alu_pkg::OP_FXMUL, 16'h4000, 16'h0800);
        add_row(alu_pkg::OP_FXMUL, 16'h4000, 16'hF400);
        repeat (4) add_row(alu_pkg::OP_FXMAC, 16'h0400, 16'h0400);
        add_row(alu_pkg::OP_FXMAC, 16'h7FFF, 16'h7FFF);
        add_row(alu_pkg::OP_FXMAC, 16'h0400, 16'h0400);
        add_row(alu_pkg::OP_CLZ, 16'h0000, 16'h0000);
        add_row(alu_pkg::OP_CLZ, 16'h8000, 16'h0000);
        add_row(alu_pkg::OP_CLZ, 16'h0001, 16'h0000);
        add_row(alu_pkg::OP_LRCW, 16'h0000, 16'h1234);
        add_row(alu_pkg::OP_LRCW, 16'hFFFF, 16'h1234);
        add_row(alu_pkg::OP_LRCW, 16'h0003, 16'h8001);
        for (int k = 0; k <= 9; k++) begin
            add_row(alu_pkg::OP_LFSR, 16'hACE1, DATA_W'(k));
        end
        add_row(4'd4, 16'h1234, 16'h5678);
        add_row(4'd8, 16'h7FFF, 16'h7FFF);
        add_row(4'd15, 16'hFFFF, 16'h0001);
        add_row(alu_pkg::OP_FXMAC, 16'h0400, 16'h0800);  // acc should be zero here
        for (int k = 0; k < N_RANDOM; k++) begin
            rnd = next_random();
            r.op = {1'b0, rnd[26:24]};
            rnd = next_random();
            r.a = rnd[31:16];
            rnd = next_random();
            r.b = (r.op == alu_pkg::OP_LFSR) ? DATA_W'(rnd[31:16] % 12) : rnd[31:16];
            add_row(r.op, r.a, r.b);
        end
        acc_model = '0;
        foreach (rows[i]) begin
            r          = rows[i];
            r.expected = expected_result(r.op, r.a, r.b, acc_model);
            acc_model  = r.expected;
            rows[i]    = r;
        end
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            err_count++;
            $display("FAIL at %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
            $display("=== FAIL ===");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // busy and valid rhythm once running
    always @(negedge i_clk) begin
        if (rhythm_on) begin
            check_value(32'(o_busy), 32'(!o_valid), "busy not the inverse of valid");
            check_value(32'(o_valid), 32'(!last_valid), "valid did not alternate");
        end
        last_valid <= o_valid;
    end

    initial begin
        wait (rows_built);
        #((rows.size() * 4 + RESET_CYCLES + 16) * CLK_PERIOD);
        $display("watchdog: the run timed out before every row was checked");
        $display("=== FAIL ===");
        $fatal(1, "timeout");
    end

    initial begin
        i_rst_n  = 1'b0;
        i_inst   = 4'd0;
        i_data_a = '0;
        i_data_b = '0;
        build_rows();
        rows_built = 1'b1;
        repeat (RESET_CYCLES) @(negedge i_clk);
        check_value(32'(o_busy), 32'd1, "busy low during reset");
        check_value(32'(o_valid), 32'd0, "valid high during reset");
        i_rst_n = 1'b1;
        @(negedge i_clk);
        check_value(32'({o_busy, o_valid}), 32'd0, "first cycle after reset not idle");
        @(negedge i_clk);
        check_value(32'({o_busy, o_valid}), 32'b10, "second cycle after reset not busy");
        @(negedge i_clk);
        check_value(32'({o_busy, o_valid}), 32'b01, "third cycle after reset not valid");
        rhythm_on = 1'b1;
        foreach (rows[i]) begin
            @(negedge i_clk);
            i_inst   = rows[i].op;
            i_data_a = rows[i].a;
            i_data_b = rows[i].b;
            do @(negedge i_clk); while (!o_valid);
            check_value(32'(o_data), 32'(rows[i].expected),
                        $sformatf("row %0d op %0d a %h b %h", i, rows[i].op, rows[i].a,
                                  rows[i].b));
        end
        if (err_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("=== FAIL ===");
            $fatal(1, "mismatches seen");
        end
    end

endmodule

//--- verilog/alu_top.sv
`timescale 1ns/1ps

module alu_top #(
    parameter int  INT_W  = 6,
    parameter int  FRAC_W = 10,
    localparam int DATA_W = INT_W + FRAC_W
) (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic signed [DATA_W-1:0] i_data_a,
    input  logic signed [DATA_W-1:0] i_data_b,
    input  logic        [3:0]        i_inst,
    output logic                     o_valid,
    output logic                     o_busy,
    output logic        [DATA_W-1:0] o_data
);

    alu_pkg::alu_op_e     op;
    alu_pkg::seq_status_t status;
    logic [DATA_W-1:0]    fx_result;
    logic [DATA_W-1:0]    bit_result;
    logic [DATA_W-1:0]    acc;

    assign op = alu_pkg::alu_op_e'(i_inst);

    issue_sequencer issue_sequencer_inst (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .o_status (status)
    );

    fx_arith_unit #(
        .INT_W  (INT_W),
        .FRAC_W (FRAC_W)
    ) fx_arith_unit_inst (
        .i_op     (op),
        .i_data_a (i_data_a),
        .i_data_b (i_data_b),
        .i_acc    (acc),        // mac reads back the last valid result
        .o_result (fx_result)
    );

    bit_manip_unit #(
        .DATA_W (DATA_W)
    ) bit_manip_unit_inst (
        .i_op     (op),
        .i_data_a (i_data_a),
        .i_data_b (i_data_b),
        .o_result (bit_result)
    );

    result_stage #(
        .DATA_W (DATA_W)
    ) result_stage_inst (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_op         (op),
        .i_status     (status),
        .i_fx_result  (fx_result),
        .i_bit_result (bit_result),
        .o_acc        (acc),
        .o_data       (o_data),
        .o_valid      (o_valid),
        .o_busy       (o_busy)
    );

endmodule

//--- verilog/result_stage.sv
`timescale 1ns/1ps

module result_stage #(
    parameter int DATA_W = 16
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  alu_pkg::alu_op_e     i_op,
    input  alu_pkg::seq_status_t i_status,
    input  logic [DATA_W-1:0]    i_fx_result,
    input  logic [DATA_W-1:0]    i_bit_result,
    output logic [DATA_W-1:0]    o_acc,
    output logic [DATA_W-1:0]    o_data,
    output logic                 o_valid,
    output logic                 o_busy
);

    always_comb begin
        case (i_op)
            alu_pkg::OP_FXADD, alu_pkg::OP_FXSUB, alu_pkg::OP_FXMUL, alu_pkg::OP_FXMAC:
                o_data = i_fx_result;
            alu_pkg::OP_CLZ, alu_pkg::OP_LRCW, alu_pkg::OP_LFSR:
                o_data = i_bit_result;
            default:
                o_data = '0;  // reserved
        endcase
    end

    // accumulator takes each valid result
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_acc <= '0;
        end else if (i_status.valid) begin
            o_acc <= o_data;
        end
    end

    assign o_valid = i_status.valid;
    assign o_busy  = i_status.busy;

    // reserved result seen through the accumulator
    a_reserved_zero: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_status.valid &&
        !(i_op inside {alu_pkg::OP_FXADD, alu_pkg::OP_FXSUB, alu_pkg::OP_FXMUL,
                       alu_pkg::OP_FXMAC, alu_pkg::OP_CLZ, alu_pkg::OP_LRCW,
                       alu_pkg::OP_LFSR}) |=> (o_acc == '0)
    ) else $error("reserved opcode left a nonzero accumulator");

endmodule

//--- bit_manip/bit_manip_unit.sv
`timescale 1ns/1ps

module bit_manip_unit #(
    parameter int DATA_W = 16
) (
    input  alu_pkg::alu_op_e  i_op,
    input  logic [DATA_W-1:0] i_data_a,
    input  logic [DATA_W-1:0] i_data_b,
    output logic [DATA_W-1:0] o_result
);

    localparam int CNT_W = $clog2(DATA_W + 1);

    logic [CNT_W-1:0]  lead_zeros;
    logic [CNT_W-1:0]  ones;
    logic [DATA_W-1:0] rotated;
    logic [DATA_W-1:0] wrap_mask;
    logic [DATA_W-1:0] lfsr_state;

    // one shift with feedback from the four top taps
    function automatic logic [DATA_W-1:0] lfsr_next(input logic [DATA_W-1:0] s);
        logic fb;
        fb = s[DATA_W-1] ^ s[DATA_W-3] ^ s[DATA_W-4] ^ s[DATA_W-6];
        return {s[DATA_W-2:0], fb};
    endfunction

    // highest set bit wins
    always_comb begin
        lead_zeros = CNT_W'(DATA_W);
        for (int i = 0; i < DATA_W; i++) begin
            if (i_data_a[i]) begin
                lead_zeros = CNT_W'(DATA_W - 1 - i);
            end
        end
    end

    always_comb begin
        ones = '0;
        for (int i = 0; i < DATA_W; i++) begin
            ones = ones + CNT_W'(i_data_a[i]);
        end
    end

    assign rotated   = (i_data_b << ones) | (i_data_b >> (DATA_W - ones));
    assign wrap_mask = ~({DATA_W{1'b1}} << ones);  // the bits that wrapped around

    always_comb begin
        lfsr_state = i_data_a;
        for (int step = 1; step <= 8; step++) begin
            if (i_data_b >= DATA_W'(step)) begin
                lfsr_state = lfsr_next(lfsr_state);
            end
        end
        if (i_data_b > DATA_W'(8)) begin
            lfsr_state = '0;  // step count out of range
        end
    end

    always_comb begin
        case (i_op)
            alu_pkg::OP_CLZ:  o_result = DATA_W'(lead_zeros);
            alu_pkg::OP_LRCW: o_result = rotated ^ wrap_mask;
            alu_pkg::OP_LFSR: o_result = lfsr_state;
            default:          o_result = '0;
        endcase
    end

endmodule

//--- fx_arith/fx_arith_unit.sv
`timescale 1ns/1ps

module fx_arith_unit #(
    parameter int  INT_W  = 6,
    parameter int  FRAC_W = 10,
    localparam int DATA_W = INT_W + FRAC_W
) (
    input  alu_pkg::alu_op_e         i_op,
    input  logic signed [DATA_W-1:0] i_data_a,
    input  logic signed [DATA_W-1:0] i_data_b,
    input  logic signed [DATA_W-1:0] i_acc,
    output logic        [DATA_W-1:0] o_result
);

    // wide enough for a full product plus the scaled accumulator
    localparam int WIDE_W = 2 * DATA_W + 1;

    localparam logic signed [WIDE_W-1:0] SAT_MAX =
        {{(DATA_W + 2){1'b0}}, {(DATA_W - 1){1'b1}}};
    localparam logic signed [WIDE_W-1:0] SAT_MIN =
        {{(DATA_W + 2){1'b1}}, {(DATA_W - 1){1'b0}}};

    logic signed [WIDE_W-1:0] add_wide;
    logic signed [WIDE_W-1:0] sub_wide;
    logic signed [WIDE_W-1:0] prod;
    logic signed [WIDE_W-1:0] acc_scaled;
    logic signed [WIDE_W-1:0] prod_sel;
    logic signed [WIDE_W-1:0] prod_round;

    // clamp to the word range
    function automatic logic [DATA_W-1:0] sat_word(input logic signed [WIDE_W-1:0] v);
        logic [DATA_W-1:0] w;
        if (v > SAT_MAX) begin
            w = {1'b0, {(DATA_W - 1){1'b1}}};
        end else if (v < SAT_MIN) begin
            w = {1'b1, {(DATA_W - 1){1'b0}}};
        end else begin
            w = v[DATA_W-1:0];
        end
        return w;
    endfunction

    assign add_wide = i_data_a + i_data_b;
    assign sub_wide = i_data_a - i_data_b;

    // product carries 2*FRAC_W fraction bits, so the accumulator is lifted by FRAC_W
    assign prod       = i_data_a * i_data_b;
    assign acc_scaled = i_acc <<< FRAC_W;
    assign prod_sel   = (i_op == alu_pkg::OP_FXMAC) ? prod + acc_scaled : prod;

    // round half up on the first dropped bit
    assign prod_round = (prod_sel >>> FRAC_W) + $signed({1'b0, prod_sel[FRAC_W-1]});

    always_comb begin
        case (i_op)
            alu_pkg::OP_FXADD: o_result = sat_word(add_wide);
            alu_pkg::OP_FXSUB: o_result = sat_word(sub_wide);
            alu_pkg::OP_FXMUL,
            alu_pkg::OP_FXMAC: o_result = sat_word(prod_round);
            default:           o_result = '0;
        endcase
    end

    // like-signed operands can only saturate, never wrap across zero
    always_comb begin
        if (i_op == alu_pkg::OP_FXADD && i_data_a[DATA_W-1] == i_data_b[DATA_W-1]) begin
            a_add_sign: assert final (o_result[DATA_W-1] == i_data_a[DATA_W-1])
                else $error("fx add flipped the sign of like-signed operands");
        end
    end

endmodule

//--- verilog/issue_sequencer.sv
`timescale 1ns/1ps

module issue_sequencer (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    output alu_pkg::seq_status_t o_status
);

    alu_pkg::seq_state_e state;
    alu_pkg::seq_state_e state_nxt;

    always_comb begin
        case (state)
            alu_pkg::ST_RESET: state_nxt = alu_pkg::ST_IDLE;
            alu_pkg::ST_IDLE:  state_nxt = alu_pkg::ST_BUSY;
            alu_pkg::ST_BUSY:  state_nxt = alu_pkg::ST_VALID;
            default:           state_nxt = alu_pkg::ST_BUSY;  // valid goes back to busy
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= alu_pkg::ST_RESET;
        end else begin
            state <= state_nxt;
        end
    end

    assign o_status.busy  = (state == alu_pkg::ST_RESET) || (state == alu_pkg::ST_BUSY);
    assign o_status.valid = (state == alu_pkg::ST_VALID);

    // never both at once, reset included
    a_busy_valid_excl: assert property (
        @(posedge i_clk) !(o_status.busy && o_status.valid)
    ) else $error("busy and valid high together");

    // free-running rhythm leaves a gap after every valid
    a_valid_gap: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_status.valid |=> !o_status.valid
    ) else $error("valid high on consecutive cycles");

endmodule

//--- common/alu_pkg.sv
package alu_pkg;

    // opcodes; 4 and 8..15 reserved
    typedef enum logic [3:0] {
        OP_FXADD = 4'd0,
        OP_FXSUB = 4'd1,
        OP_FXMUL = 4'd2,
        OP_FXMAC = 4'd3,
        OP_CLZ   = 4'd5,
        OP_LRCW  = 4'd6,
        OP_LFSR  = 4'd7
    } alu_op_e;

    // issue sequencer states
    typedef enum logic [1:0] {
        ST_RESET = 2'd0,  // busy, not valid
        ST_IDLE  = 2'd1,  // first cycle out of reset, quiet
        ST_BUSY  = 2'd2,
        ST_VALID = 2'd3
    } seq_state_e;

    typedef struct packed {
        logic busy;
        logic valid;
    } seq_status_t;

endpackage
